//--- hw/pack_defs.svh
`ifndef PACK_DEFS_SVH
`define PACK_DEFS_SVH

// One pushed sample and one packed line.
`define PACK_IN_W 16
`define PACK_OUT_W 128

`define PACK_LANES (`PACK_OUT_W / `PACK_IN_W) // Samples per line.

// Line store size.
`define PACK_DEPTH 16
`define PACK_ADDR_W 4

`endif

//--- hw/pack_pkg.sv
package pack_pkg;

  `include "pack_defs.svh"

  typedef logic [`PACK_IN_W-1:0] sample_t;
  typedef logic [`PACK_OUT_W-1:0] line_t;
  typedef logic [`PACK_ADDR_W-1:0] line_addr_t;
  typedef logic [`PACK_ADDR_W:0] line_count_t; // Can hold PACK_DEPTH itself.

  // In a hold state the named buffer is full and the other one is filling.
  typedef enum logic [1:0] {
    fill_a,
    hold_a,
    fill_b,
    hold_b
  } pack_state_e;

endpackage

//--- hw/mem_port_if.sv
`timescale 1ns/1ns

interface mem_port_if;

  // Write side.
  logic we;
  pack_pkg::line_addr_t waddr;
  pack_pkg::line_t wdata;

  // Read side. rdata follows re by one cycle.
  logic re;
  pack_pkg::line_addr_t raddr;
  pack_pkg::line_t rdata;

  modport writer (
    output we, waddr, wdata,
    output re, raddr,
    input  rdata
  );

  modport memory (
    input  we, waddr, wdata,
    input  re, raddr,
    output rdata
  );

endinterface

//--- hw/word_packer.sv
`timescale 1ns/1ns
`include "pack_defs.svh"

module word_packer (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  pack_pkg::sample_t din,
  output logic              push_ready,
  input  logic              line_ready,
  output logic              line_valid,
  output pack_pkg::line_t   line_data
);

  localparam logic [`PACK_LANES-1:0] first_lane = 1;

  pack_pkg::pack_state_e state_q;
  pack_pkg::line_t buf_a;
  pack_pkg::line_t buf_b;

  // One-hot slot for the next sample of whichever buffer is filling.
  // It shifts out to zero once that buffer is full.
  logic [`PACK_LANES-1:0] lane_q;

  logic take;
  logic accept;
  logic to_a;
  logic last_lane;
  logic fill_full;
  logic acc_a_q;
  logic acc_b_q;

  assign take = push & push_ready;
  assign accept = line_ready &
                  (state_q == pack_pkg::hold_a || state_q == pack_pkg::hold_b);

  // Buffer A fills in fill_a and while B waits in hold_b.
  assign to_a = (state_q == pack_pkg::fill_a) || (state_q == pack_pkg::hold_b);

  assign last_lane = lane_q[`PACK_LANES-1];

  // The filling buffer is full at the end of this cycle.
  assign fill_full = (lane_q == '0) | (take & last_lane);

  // New samples enter at the top, so the first one ends up in lane 0.
  always_ff @(posedge clk) begin
    if (take && to_a) begin
      buf_a <= {din, buf_a[`PACK_OUT_W-1:`PACK_IN_W]};
    end
    if (take && !to_a) begin
      buf_b <= {din, buf_b[`PACK_OUT_W-1:`PACK_IN_W]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= pack_pkg::fill_a;
      lane_q <= first_lane;
      push_ready <= 1'b1;
    end else begin
      if (take) begin
        lane_q <= lane_q << 1;
      end
      case (state_q)
        pack_pkg::fill_a: begin
          if (take && last_lane) begin
            state_q <= pack_pkg::hold_a;
            lane_q <= first_lane; // B starts empty.
          end
        end
        pack_pkg::hold_a: begin
          if (line_ready) begin
            push_ready <= 1'b1; // A is free again.
            if (fill_full) begin
              state_q <= pack_pkg::hold_b;
              lane_q <= first_lane;
            end else begin
              state_q <= pack_pkg::fill_b;
            end
          end else if (take && last_lane) begin
            push_ready <= 1'b0; // Both buffers full.
          end
        end
        pack_pkg::fill_b: begin
          if (take && last_lane) begin
            state_q <= pack_pkg::hold_b;
            lane_q <= first_lane;
          end
        end
        pack_pkg::hold_b: begin
          if (line_ready) begin
            push_ready <= 1'b1;
            if (fill_full) begin
              state_q <= pack_pkg::hold_a;
              lane_q <= first_lane;
            end else begin
              state_q <= pack_pkg::fill_a;
            end
          end else if (take && last_lane) begin
            push_ready <= 1'b0;
          end
        end
        default: begin
          state_q <= pack_pkg::fill_a;
        end
      endcase
    end
  end

  // Two stages from accept to line_valid.
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_a_q <= 1'b0;
      acc_b_q <= 1'b0;
      line_valid <= 1'b0;
    end else begin
      acc_a_q <= accept && (state_q == pack_pkg::hold_a);
      acc_b_q <= accept && (state_q == pack_pkg::hold_b);
      line_valid <= acc_a_q | acc_b_q;
    end
  end

  // The accepted buffer cannot be refilled before this capture edge.
  always_ff @(posedge clk) begin
    if (acc_a_q) begin
      line_data <= buf_a;
    end else if (acc_b_q) begin
      line_data <= buf_b;
    end
  end

  push_only_when_ready: assert property (
    @(posedge clk) disable iff (rst) push |-> push_ready
  ) else $error("push while push_ready is low");

  // Lines must alternate between the buffers when they come back to back.
  no_repeat_source: assert property (
    @(posedge clk) disable iff (rst)
      (acc_a_q |=> !acc_a_q) and (acc_b_q |=> !acc_b_q)
  ) else $error("two consecutive lines from the same buffer");

endmodule

//--- hw/line_writer.sv
`timescale 1ns/1ns
`include "pack_defs.svh"

module line_writer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clear,
  input  logic                  line_valid,
  input  pack_pkg::line_t       line_data,
  output logic                  line_ready,
  input  logic                  rd_en,
  input  pack_pkg::line_addr_t  rd_addr,
  output pack_pkg::line_t       rd_data,
  output pack_pkg::line_count_t line_count,
  mem_port_if.writer            mem
);

  localparam pack_pkg::line_count_t depth = `PACK_DEPTH;

  logic store;

  // A line that finds the store full is dropped.
  assign store = line_valid && (line_count != depth);

  // The count doubles as the write pointer.
  assign mem.we = store;
  assign mem.waddr = line_count[`PACK_ADDR_W-1:0];
  assign mem.wdata = line_data;

  // Host reads go straight to the read port.
  assign mem.re = rd_en;
  assign mem.raddr = rd_addr;
  assign rd_data = mem.rdata;

  // Keeps two slots free for lines that may already be in flight.
  assign line_ready = line_count < (depth - 1'b1);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      line_count <= '0;
    end else if (store) begin
      line_count <= line_count + 1'b1;
    end
  end

  no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) line_valid |-> line_count != depth
  ) else $error("line_valid with the line store full");

endmodule

//--- hw/line_ram.sv
`timescale 1ns/1ns
`include "pack_defs.svh"

module line_ram (
  input logic         clk,
  mem_port_if.memory  mem
);

  pack_pkg::line_t mem_q [`PACK_DEPTH];
  pack_pkg::line_t rdata_q;

  // A read of the address being written returns the old line.
  always_ff @(posedge clk) begin
    if (mem.we) begin
      mem_q[mem.waddr] <= mem.wdata;
    end
    if (mem.re) begin
      rdata_q <= mem_q[mem.raddr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

//--- hw/pack_top.sv
`timescale 1ns/1ns

module pack_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  pack_pkg::sample_t     din,
  output logic                  push_ready,
  input  logic                  clear,
  input  logic                  rd_en,
  input  pack_pkg::line_addr_t  rd_addr,
  output pack_pkg::line_t       rd_data,
  output pack_pkg::line_count_t line_count
);

  logic line_valid;
  logic line_ready;
  pack_pkg::line_t line_data;

  mem_port_if mem_bus ();

  word_packer u_packer (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .din        (din),
    .push_ready (push_ready),
    .line_ready (line_ready),
    .line_valid (line_valid),
    .line_data  (line_data)
  );

  line_writer u_writer (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .line_valid (line_valid),
    .line_data  (line_data),
    .line_ready (line_ready),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .line_count (line_count),
    .mem        (mem_bus.writer)
  );

  line_ram u_ram (
    .clk (clk),
    .mem (mem_bus.memory)
  );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tb/tb_pack_top.sv
`timescale 1ns/1ns
`include "pack_defs.svh"

module tb_pack_top;

  // Upper bound on the samples the five tests push.
  localparam int max_pushes = 8 + 6 * `PACK_LANES + (`PACK_DEPTH + 2) * `PACK_LANES
                              + 3 * `PACK_LANES;
  localparam int timeout_cycles = 64 * max_pushes + 2000;
  localparam int stall_limit = 12;

  logic clk;
  logic rst;
  logic push;
  pack_pkg::sample_t din;
  logic push_ready;
  logic clear;
  logic rd_en;
  pack_pkg::line_addr_t rd_addr;
  pack_pkg::line_t rd_data;
  pack_pkg::line_count_t line_count;

  pack_pkg::sample_t pushed_q [$]; // Every sample in push order.
  int base_line; // Model line that sits at address 0.
  logic prev_full;
  logic [31:0] lfsr;
  pack_pkg::line_t exp_line;
  pack_pkg::line_t exp_q;
  logic rd_en_q;
  int err_count;
  int errs_at_start;
  int pass_tests;
  int fail_tests;
  int cycles = 0;

  tb_clock_gen clock_gen (
    .clk (clk),
    .rst (rst)
  );

  pack_top UUT (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .din        (din),
    .push_ready (push_ready),
    .clear      (clear),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .line_count (line_count)
  );

  // rd_data shows up one cycle after the RAM sees rd_en.
  always @(posedge clk) begin
    rd_en_q <= rd_en;
    exp_q <= exp_line;
  end

  reset_ready: assert property (
    @(posedge clk) $fell(rst) |-> push_ready
  ) else begin
    $display("[FAIL] push_ready after reset expected 1 got %h", $sampled(push_ready));
    err_count++;
  end

  reset_count: assert property (
    @(posedge clk) $fell(rst) |-> line_count == 0
  ) else begin
    $display("[FAIL] line_count after reset expected 0 got %h", $sampled(line_count));
    err_count++;
  end

  read_matches: assert property (
    @(posedge clk) disable iff (rst) rd_en_q |-> rd_data == exp_q
  ) else begin
    $display("[FAIL] rd_data expected %h got %h", $sampled(exp_q), $sampled(rd_data));
    err_count++;
  end

  count_never_drops: assert property (
    @(posedge clk) disable iff (rst) !clear |=> line_count >= $past(line_count)
  ) else begin
    $display("[FAIL] line_count expected at least %h got %h",
             $past(line_count), $sampled(line_count));
    err_count++;
  end

  count_in_range: assert property (
    @(posedge clk) disable iff (rst) line_count <= `PACK_DEPTH
  ) else begin
    $display("[FAIL] line_count expected at most %h got %h",
             `PACK_DEPTH, $sampled(line_count));
    err_count++;
  end

  push_respects_ready: assert property (
    @(posedge clk) disable iff (rst) push |-> push_ready
  ) else begin
    $display("A sample was pushed while push_ready was low.");
    err_count++;
  end

  clear_empties: assert property (
    @(posedge clk) disable iff (rst) clear |=> line_count == 0
  ) else begin
    $display("[FAIL] line_count after clear expected 0 got %h", $sampled(line_count));
    err_count++;
  end

  clear_resumes: assert property (
    @(posedge clk) disable iff (rst) clear |=> ##[0:3] push_ready
  ) else begin
    $display("push_ready did not come back high after clear.");
    err_count++;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // Takes n bits with one LFSR step per bit.
  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Lane i of line k is sample k * lanes + i.
  function automatic pack_pkg::line_t expect_line(input int k);
    pack_pkg::line_t l;
    l = '0;
    for (int i = 0; i < `PACK_LANES; i++) begin
      l[i*`PACK_IN_W +: `PACK_IN_W] = pushed_q[k*`PACK_LANES + i];
    end
    return l;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      push <= 1'b0;
      clear <= 1'b0;
      rd_en <= 1'b0;
      prev_full = 1'b0;
    end
  endtask

  // push_ready can only fall after a push that completes a line,
  // so one quiet edge follows such a push before push_ready is trusted.
  task automatic try_push(input pack_pkg::sample_t s, output logic sent);
    @(posedge clk);
    clear <= 1'b0;
    rd_en <= 1'b0;
    if (push_ready && !prev_full) begin
      push <= 1'b1;
      din <= s;
      pushed_q.push_back(s);
      prev_full = (pushed_q.size() % `PACK_LANES) == 0;
      sent = 1'b1;
    end else begin
      push <= 1'b0;
      prev_full = 1'b0;
      sent = 1'b0;
    end
  endtask

  task automatic drive_push(input pack_pkg::sample_t s);
    logic sent;
    sent = 1'b0;
    while (!sent) begin
      try_push(s, sent);
    end
  endtask

  task automatic strobe_clear();
    @(posedge clk);
    push <= 1'b0;
    rd_en <= 1'b0;
    clear <= 1'b1;
    prev_full = 1'b0;
    base_line += int'(line_count); // Held lines land from address 0 after this.
    idle(1);
  endtask

  task automatic wait_count(input int n);
    idle(1);
    while (int'(line_count) != n) begin
      idle(1);
    end
  endtask

  task automatic read_line(input int addr);
    @(posedge clk);
    push <= 1'b0;
    clear <= 1'b0;
    rd_en <= 1'b1;
    rd_addr <= pack_pkg::line_addr_t'(addr);
    exp_line <= expect_line(base_line + addr);
    prev_full = 1'b0;
  endtask

  task automatic read_all(input int n);
    for (int a = 0; a < n; a++) begin
      read_line(a);
    end
    idle(3);
  endtask

  task automatic end_test(input string name);
    idle(4);
    if (err_count == errs_at_start) begin
      pass_tests++;
      $display("%s: ok", name);
    end else begin
      fail_tests++;
      $display("%s: %0d errors", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  initial begin
    pack_pkg::sample_t s;
    logic [15:0] gap;
    logic sent;
    int stall;
    int lines;

    push = 1'b0;
    din = '0;
    clear = 1'b0;
    rd_en = 1'b0;
    rd_addr = '0;
    exp_line = '0;
    lfsr = 32'd67259;
    base_line = 0;
    prev_full = 1'b0;
    err_count = 0;
    errs_at_start = 0;
    pass_tests = 0;
    fail_tests = 0;

    idle(1);
    while (rst !== 1'b0) begin
      idle(1);
    end
    idle(2);
    end_test("reset state");

    for (int i = 0; i < `PACK_LANES; i++) begin
      draw_bits(16, s);
      drive_push(s);
    end
    wait_count(1);
    read_all(1);
    end_test("lane order");

    strobe_clear();
    for (int i = 0; i < 6 * `PACK_LANES; i++) begin
      draw_bits(16, s);
      drive_push(s);
      draw_bits(2, gap);
      idle(int'(gap));
    end
    wait_count(6);
    read_all(6);
    end_test("random gaps");

    // Keep pushing until the full store stalls both buffers.
    stall = 0;
    draw_bits(16, s);
    while (stall < stall_limit) begin
      try_push(s, sent);
      if (sent) begin
        draw_bits(16, s);
        stall = 0;
      end else begin
        stall++;
      end
    end
    lines = int'(line_count);
    read_all(lines);
    end_test("back-pressure");

    strobe_clear();
    for (int i = 0; i < 3 * `PACK_LANES; i++) begin
      draw_bits(16, s);
      drive_push(s);
    end
    lines = pushed_q.size() / `PACK_LANES - base_line;
    wait_count(lines);
    read_all(lines);
    end_test("clear and resume");

    $display("Summary: %0d ok, %0d failed", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish.", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+hw
hw/pack_pkg.sv
hw/mem_port_if.sv
hw/word_packer.sv
hw/line_writer.sv
hw/line_ram.sv
hw/pack_top.sv
tb/tb_clock_gen.sv
tb/tb_pack_top.sv

//--- Bender.yml
package:
  name: line_packer

sources:
  - include_dirs:
      - hw
    files:
      - hw/pack_pkg.sv
      - hw/mem_port_if.sv
      - hw/word_packer.sv
      - hw/line_writer.sv
      - hw/line_ram.sv
      - hw/pack_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_pack_top.sv
